// ==== bench/tb_checks.svh ====
/*
 * multiply issue path testbench helpers
 * reference multiply model, xorshift generator and typed compares
 * for results seen on the cdb
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// xorshift32, shifts 13 / 17 / 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// 64 bit product of the operands as the function reads them
function automatic xlen_t ref_mul(input mul_func_t f, input xlen_t a, input xlen_t b);
    logic [2*XLEN-1:0] wa;
    logic [2*XLEN-1:0] wb;
    logic [2*XLEN-1:0] prod;
    wa = {{XLEN{1'b0}}, a};                                       // unsigned by default
    wb = {{XLEN{1'b0}}, b};
    if (f == MUL_HI_SS || f == MUL_HI_SU) wa = {{XLEN{a[XLEN-1]}}, a};
    if (f == MUL_HI_SS) wb = {{XLEN{b[XLEN-1]}}, b};
    prod = wa * wb;                  // modulo 2^64 keeps every sign mix exact
    return (f == MUL_LO) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
endfunction

task automatic report_failure(input string msg);
    n_errors++;
    $display("%s: %s", cur_test, msg);
endtask

task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    n_checks++;
    if (exp !== act) begin
        n_errors++;
        $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_preg(input string what, input preg_idx_t exp, input preg_idx_t act);
    n_checks++;
    if (exp !== act) begin
        n_errors++;
        $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

task automatic check_rob(input string what, input rob_idx_t exp, input rob_idx_t act);
    n_checks++;
    if (exp !== act) begin
        n_errors++;
        $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
endtask

`endif

// ==== bench/tb_mul_issue.sv ====
/*
 * multiply issue path testbench
 * directed tests of ready dispatch, cdb wakeup, station full,
 * alu priority on the cdb and misprediction squash
 */
`default_nettype none

module tb_mul_issue import mul_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic      clock;
    logic      reset;
    logic      commit_mis_pred;
    logic      dispatch_en;
    logic      opa_ready, opb_ready;
    xlen_t     opa_value, opb_value;
    preg_idx_t opa_preg, opb_preg, dest_preg;
    rob_idx_t  rob_idx;
    mul_func_t func;
    logic      alu_valid;
    preg_idx_t alu_dest;
    rob_idx_t  alu_rob;
    xlen_t     alu_value;
    logic      cdb_valid, cdb_is_mul, rs_full;
    preg_idx_t cdb_dest;
    xlen_t     cdb_value;
    rob_idx_t  cdb_rob;

    string       cur_test;
    int          n_checks;
    int          n_errors;
    int          test_base;            // error count at test start
    logic [31:0] rng_state;
    xlen_t       exp_val  [32];        // expected result per rob slot
    preg_idx_t   exp_dest [32];
    logic        exp_live [32];        // result still owed
    rob_idx_t    mul_rob_q [$];        // multiply broadcasts in arrival order
    preg_idx_t   mul_dest_q [$];
    xlen_t       mul_val_q [$];
    int          mul_alu_q [$];        // alu broadcasts seen before each multiply
    xlen_t       alu_val_q [$];
    preg_idx_t   alu_dest_q [$];
    rob_idx_t    alu_rob_q [$];

    `include "tb_checks.svh"

    mul_issue_top u_mul_issue_top (.*);

    always #2 clock = ~clock;          // 4 ns period

    // cdb sampled on the falling edge, clear of the driving edge
    always @(negedge clock) begin
        if (!reset && cdb_valid && cdb_is_mul) begin
            mul_rob_q.push_back(cdb_rob);
            mul_dest_q.push_back(cdb_dest);
            mul_val_q.push_back(cdb_value);
            mul_alu_q.push_back(alu_val_q.size());
        end else if (!reset && cdb_valid) begin
            alu_val_q.push_back(cdb_value);
            alu_dest_q.push_back(cdb_dest);
            alu_rob_q.push_back(cdb_rob);
        end
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    function xlen_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic set_dispatch(input mul_func_t f, input logic ar, input xlen_t a,
                                input preg_idx_t ap, input logic br, input xlen_t b,
                                input preg_idx_t bp, input preg_idx_t d, input rob_idx_t r);
        func      <= f;
        opa_ready <= ar;
        opa_value <= a;
        opa_preg  <= ap;                // tag only matters while waiting
        opb_ready <= br;
        opb_value <= b;
        opb_preg  <= bp;
        dest_preg <= d;
        rob_idx   <= r;
    endtask

    task automatic dispatch_op(input mul_func_t f, input logic ar, input xlen_t a,
                               input preg_idx_t ap, input logic br, input xlen_t b,
                               input preg_idx_t bp, input preg_idx_t d, input rob_idx_t r);
        @(posedge clock);
        set_dispatch(f, ar, a, ap, br, b, bp, d, r);
        dispatch_en <= 1'b1;
        @(posedge clock);
        dispatch_en <= 1'b0;            // one-cycle strobe
    endtask

    task automatic drive_alu(input logic v, input preg_idx_t d, input rob_idx_t r,
                             input xlen_t x);
        alu_valid <= v;
        alu_dest  <= d;
        alu_rob   <= r;
        alu_value <= x;
    endtask

    task automatic squash();
        @(posedge clock);
        commit_mis_pred <= 1'b1;
        @(posedge clock);
        commit_mis_pred <= 1'b0;
    endtask

    task automatic expect_mul(input mul_func_t f, input xlen_t a, input xlen_t b,
                              input preg_idx_t d, input rob_idx_t r);
        exp_val[r]  = ref_mul(f, a, b);
        exp_dest[r] = d;
        exp_live[r] = 1'b1;
    endtask

    // each test starts from an empty, never-issued station
    task automatic begin_test(input string name);
        cur_test  = name;
        test_base = n_errors;
        squash();
        foreach (exp_live[i]) exp_live[i] = 1'b0;
        mul_rob_q.delete();
        mul_dest_q.delete();
        mul_val_q.delete();
        mul_alu_q.delete();
        alu_val_q.delete();
        alu_dest_q.delete();
        alu_rob_q.delete();
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", cur_test, n_errors - test_base);
    endtask

    task automatic wait_mul(input int n);
        int cycles;
        cycles = 0;
        while (mul_val_q.size() < n && cycles < 100) begin
            @(negedge clock);
            cycles++;
        end
        if (mul_val_q.size() < n)
            report_failure($sformatf("timed out with %0d of %0d multiply results on the cdb",
                                     mul_val_q.size(), n));
    endtask

    // match broadcasts to expectations by rob slot
    task automatic check_results();
        rob_idx_t r;
        foreach (mul_rob_q[i]) begin
            r = mul_rob_q[i];
            if (!exp_live[r]) begin
                report_failure($sformatf("unexpected multiply result for rob %0d", r));
            end else begin
                check_xlen("result", exp_val[r], mul_val_q[i]);
                check_preg("dest", exp_dest[r], mul_dest_q[i]);
                exp_live[r] = 1'b0;
            end
        end
        foreach (exp_live[i])
            if (exp_live[i]) report_failure($sformatf("no result for rob %0d", i));
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_ready_ops();
        xlen_t a;
        xlen_t b;
        begin_test("test_ready_ops");
        for (int i = 0; i < 4; i++) begin       // one of each function
            a = next_rand();
            b = next_rand();
            expect_mul(mul_func_t'(i), a, b, preg_idx_t'(10 + i), rob_idx_t'(i));
            dispatch_op(mul_func_t'(i), 1'b1, a, '0, 1'b1, b, '0,
                        preg_idx_t'(10 + i), rob_idx_t'(i));
        end
        wait_mul(4);
        check_results();
        end_test();
    endtask

    task automatic test_wakeup();
        xlen_t va;
        xlen_t vb;
        xlen_t a;
        xlen_t b;
        begin_test("test_wakeup");
        va = next_rand();
        vb = next_rand();
        a  = next_rand();
        b  = next_rand();
        expect_mul(MUL_HI_SS, va, b, 6'd30, 5'd8);
        expect_mul(MUL_HI_SU, a, vb, 6'd31, 5'd9);
        dispatch_op(MUL_HI_SS, 1'b0, '0, 6'd20, 1'b1, b, '0, 6'd30, 5'd8);  // a waits on p20
        drive_alu(1'b1, 6'd20, 5'd1, va);
        @(posedge clock);
        drive_alu(1'b1, 6'd21, 5'd2, vb);
        @(posedge clock);                       // p21 is on the cdb next cycle
        drive_alu(1'b0, '0, '0, '0);
        set_dispatch(MUL_HI_SU, 1'b1, a, '0, 1'b0, '0, 6'd21, 6'd31, 5'd9);
        dispatch_en <= 1'b1;                    // lands with p21 on the bus
        @(posedge clock);
        dispatch_en <= 1'b0;
        wait_mul(2);
        check_results();
        end_test();
    endtask

    task automatic test_alu_priority();
        xlen_t a;
        xlen_t b;
        begin_test("test_alu_priority");
        a = next_rand();
        b = next_rand();
        expect_mul(MUL_HI_UU, a, b, 6'd33, 5'd12);
        dispatch_op(MUL_HI_UU, 1'b1, a, '0, 1'b1, b, '0, 6'd33, 5'd12);
        for (int i = 0; i < 10; i++) begin     // alu owns the bus across mul_done
            drive_alu(1'b1, preg_idx_t'(40 + i), rob_idx_t'(20 + i), 32'ha100_0000 + i);
            @(posedge clock);
        end
        drive_alu(1'b0, '0, '0, '0);
        wait_mul(1);
        check_results();
        if (alu_val_q.size() != 10)
            report_failure($sformatf("%0d of 10 alu results on the cdb", alu_val_q.size()));
        foreach (alu_val_q[i]) begin
            check_xlen("alu value", 32'ha100_0000 + i, alu_val_q[i]);
            check_preg("alu dest", preg_idx_t'(40 + i), alu_dest_q[i]);
            check_rob("alu rob", rob_idx_t'(20 + i), alu_rob_q[i]);
        end
        if (mul_alu_q.size() > 0 && mul_alu_q[0] != 10)
            report_failure("multiply result took the bus while the alu was broadcasting");
        end_test();
    endtask

    // four entries waiting on p50, never broadcast here
    task automatic fill_waiting();
        for (int i = 0; i < 4; i++)
            dispatch_op(MUL_LO, 1'b0, '0, 6'd50, 1'b1, next_rand(), '0,
                        preg_idx_t'(34 + i), rob_idx_t'(16 + i));
    endtask

    task automatic test_full();
        begin_test("test_full");
        fill_waiting();
        @(negedge clock);
        if (!rs_full) report_failure("rs_full is low with all four entries busy");
        repeat (20) @(negedge clock);
        if (mul_val_q.size() != 0) report_failure("multiply broadcast from waiting entries");
        end_test();
    endtask

    task automatic test_squash();
        xlen_t a;
        xlen_t b;
        begin_test("test_squash");
        fill_waiting();
        squash();
        drive_alu(1'b1, 6'd50, 5'd3, next_rand());   // wake the squashed tag
        @(posedge clock);
        drive_alu(1'b0, '0, '0, '0);
        repeat (20) @(negedge clock);
        if (mul_val_q.size() != 0) report_failure("a squashed multiply reached the cdb");
        if (rs_full) report_failure("rs_full is still high after the squash");
        a = next_rand();
        b = next_rand();
        expect_mul(MUL_HI_SS, a, b, 6'd35, 5'd24);
        dispatch_op(MUL_HI_SS, 1'b1, a, '0, 1'b1, b, '0, 6'd35, 5'd24);
        wait_mul(1);
        check_results();
        end_test();
    endtask

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////
    initial begin
        clock = 1'b0;
        reset <= 1'b1;
        commit_mis_pred <= 1'b0;
        dispatch_en <= 1'b0;
        set_dispatch(MUL_LO, 1'b0, '0, '0, 1'b0, '0, '0, '0, '0);
        drive_alu(1'b0, '0, '0, '0);
        n_checks  = 0;
        n_errors  = 0;
        rng_state = 32'hd4ef_4bae;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        test_ready_ops();
        test_wakeup();
        test_alu_priority();
        test_full();
        test_squash();
        $display("5 tests, %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/mul_pkg.sv
hdl/psel_gen.sv
hdl/rs_mul.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/mul_issue_top.sv
+incdir+bench
bench/tb_mul_issue.sv

// ==== hdl/cdb_arbiter.sv ====
/*
 * cdb arbiter
 * alu results always win the bus, a multiply result that loses
 * waits in a one-deep hold register until the bus is free
 */
`default_nettype none

module cdb_arbiter import mul_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      commit_mis_pred,
    input  wire logic      mul_done,
    input  wire xlen_t     mul_result,
    input  wire preg_idx_t mul_dest,
    input  wire rob_idx_t  mul_rob,
    input  wire logic      alu_valid,
    input  wire preg_idx_t alu_dest,
    input  wire rob_idx_t  alu_rob,
    input  wire xlen_t     alu_value,
    output logic           cdb_valid,
    output preg_idx_t      cdb_dest,
    output xlen_t          cdb_value,
    output rob_idx_t       cdb_rob,
    output logic           cdb_is_mul     // broadcast is a multiply result
);

    logic      pend_valid;                // multiply waiting for the bus
    xlen_t     pend_value;
    preg_idx_t pend_dest;
    rob_idx_t  pend_rob;
    logic      mul_avail;

    // one multiply in flight, so the hold and a new mul_done never overlap
    assign mul_avail = pend_valid | mul_done;

    always_ff @(posedge clock) begin
        if (reset || commit_mis_pred) begin
            pend_valid <= 1'b0;
            cdb_valid  <= 1'b0;
            cdb_is_mul <= 1'b0;
        end else begin
            cdb_valid  <= alu_valid | mul_avail;
            cdb_is_mul <= ~alu_valid & mul_avail;
            pend_valid <= alu_valid & mul_avail;    // blocked, keep holding
        end
    end

    always_ff @(posedge clock) begin
        if (mul_done) begin
            pend_value <= mul_result;
            pend_dest  <= mul_dest;
            pend_rob   <= mul_rob;
        end
        if (alu_valid) begin                        // alu first
            cdb_value <= alu_value;
            cdb_dest  <= alu_dest;
            cdb_rob   <= alu_rob;
        end else if (mul_avail) begin
            cdb_value <= pend_valid ? pend_value : mul_result;
            cdb_dest  <= pend_valid ? pend_dest  : mul_dest;
            cdb_rob   <= pend_valid ? pend_rob   : mul_rob;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mul_issue_top.sv ====
/*
 * multiply issue path top
 * station -> multiplier -> cdb arbiter, with the cdb fed back
 * into the station for wakeup and issue permission
 */
`default_nettype none

module mul_issue_top import mul_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      commit_mis_pred,
    // dispatch
    input  wire logic      dispatch_en,
    input  wire logic      opa_ready,
    input  wire xlen_t     opa_value,
    input  wire logic      opb_ready,
    input  wire xlen_t     opb_value,
    input  wire preg_idx_t opa_preg,
    input  wire preg_idx_t opb_preg,
    input  wire preg_idx_t dest_preg,
    input  wire rob_idx_t  rob_idx,
    input  wire mul_func_t func,
    // alu result
    input  wire logic      alu_valid,
    input  wire preg_idx_t alu_dest,
    input  wire rob_idx_t  alu_rob,
    input  wire xlen_t     alu_value,
    // cdb
    output logic           cdb_valid,
    output preg_idx_t      cdb_dest,
    output xlen_t          cdb_value,
    output rob_idx_t       cdb_rob,
    output logic           cdb_is_mul,
    output logic           rs_full
);

    logic      issue_valid;               // station -> multiplier
    xlen_t     issue_opa;
    xlen_t     issue_opb;
    mul_func_t issue_func;
    preg_idx_t issue_dest;
    rob_idx_t  issue_rob;
    logic      mul_done;                  // multiplier -> arbiter
    xlen_t     mul_result;
    preg_idx_t mul_dest;
    rob_idx_t  mul_rob;

    rs_mul u_rs_mul (
        .clock, .reset, .commit_mis_pred,
        .dispatch_en, .opa_ready, .opa_value, .opb_ready, .opb_value,
        .opa_preg, .opb_preg, .dest_preg, .rob_idx, .func,
        .cdb_valid, .cdb_dest, .cdb_value, .cdb_is_mul,   // registered cdb back in
        .issue_valid, .issue_opa, .issue_opb, .issue_func, .issue_dest, .issue_rob,
        .rs_full
    );

    mul_unit u_mul_unit (
        .clock, .reset, .commit_mis_pred,
        .issue_valid, .issue_opa, .issue_opb, .issue_func, .issue_dest, .issue_rob,
        .mul_done, .mul_result, .mul_dest, .mul_rob
    );

    cdb_arbiter u_cdb_arbiter (
        .clock, .reset, .commit_mis_pred,
        .mul_done, .mul_result, .mul_dest, .mul_rob,
        .alu_valid, .alu_dest, .alu_rob, .alu_value,
        .cdb_valid, .cdb_dest, .cdb_value, .cdb_rob, .cdb_is_mul
    );

endmodule

`default_nettype wire

// ==== hdl/mul_pkg.sv ====
/*
 * multiply issue path shared definitions
 * data and tag widths, station sizing, pipeline depth,
 * and the encoding of the four multiply functions
 */
`default_nettype none

package mul_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////
    localparam int XLEN        = 32;   // architectural data width
    localparam int PRF_LEN     = 6;    // 64 physical registers
    localparam int ROB_LEN     = 5;    // 32 rob slots
    localparam int RS_MUL_SIZE = 4;    // multiply station entries
    localparam int RS_MUL_LEN  = 2;    // log2(RS_MUL_SIZE)
    localparam int MUL_STAGES  = 3;    // extend, multiply, select

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////
    typedef logic [XLEN-1:0]        xlen_t;        // one data word
    typedef logic [PRF_LEN-1:0]     preg_idx_t;    // renamed register tag
    typedef logic [ROB_LEN-1:0]     rob_idx_t;     // reorder buffer slot
    typedef logic [RS_MUL_LEN-1:0]  rs_mul_idx_t;  // station entry number
    typedef logic [RS_MUL_SIZE-1:0] rs_mul_vec_t;  // one bit per entry

    ////////////////////////////////////////
    // multiply function
    ////////////////////////////////////////
    // MUL_LO is the same for any signedness,
    // the HI forms pick the upper word of the 64 bit product
    typedef enum logic [1:0] {
        MUL_LO    = 2'b00,  // mul
        MUL_HI_SS = 2'b01,  // mulh, signed x signed
        MUL_HI_SU = 2'b10,  // mulhsu, signed x unsigned
        MUL_HI_UU = 2'b11   // mulhu, unsigned x unsigned
    } mul_func_t;

endpackage

`default_nettype wire

// ==== hdl/mul_unit.sv ====
/*
 * three-stage 32x32 multiplier
 * stage 1 extends operands to 33 bits per function signedness,
 * stage 2 forms the 66 bit product, stage 3 picks the result word
 */
`default_nettype none

module mul_unit import mul_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      commit_mis_pred,
    input  wire logic      issue_valid,
    input  wire xlen_t     issue_opa,
    input  wire xlen_t     issue_opb,
    input  wire mul_func_t issue_func,
    input  wire preg_idx_t issue_dest,
    input  wire rob_idx_t  issue_rob,
    output logic           mul_done,      // MUL_STAGES after issue_valid
    output xlen_t          mul_result,
    output preg_idx_t      mul_dest,
    output rob_idx_t       mul_rob
);

    logic [MUL_STAGES-1:0] vld;               // bit n = stage n+1 busy

    logic                  a_signed;
    logic                  b_signed;

    logic signed [XLEN:0]  s1_opa;            // 33 bit extended
    logic signed [XLEN:0]  s1_opb;
    mul_func_t             s1_func;
    preg_idx_t             s1_dest;
    rob_idx_t              s1_rob;

    logic signed [2*XLEN+1:0] s2_prod;        // full 66 bit product
    mul_func_t             s2_func;
    preg_idx_t             s2_dest;
    rob_idx_t              s2_rob;

    ////////////////////////////////////////
    // operand signedness
    ////////////////////////////////////////
    always_comb begin
        case (issue_func)
            MUL_HI_SS: begin a_signed = 1'b1; b_signed = 1'b1; end
            MUL_HI_SU: begin a_signed = 1'b1; b_signed = 1'b0; end
            default:   begin a_signed = 1'b0; b_signed = 1'b0; end // lo word same either way
        endcase
    end

    // valid shift chain, squash drops whatever is in flight
    always_ff @(posedge clock) begin
        if (reset || commit_mis_pred) vld <= '0;
        else vld <= {vld[MUL_STAGES-2:0], issue_valid};
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin                                  // stage 1
            s1_opa  <= {a_signed & issue_opa[XLEN-1], issue_opa};
            s1_opb  <= {b_signed & issue_opb[XLEN-1], issue_opb};
            s1_func <= issue_func;
            s1_dest <= issue_dest;
            s1_rob  <= issue_rob;
        end
        if (vld[0]) begin                                       // stage 2
            s2_prod <= s1_opa * s1_opb;   // both signed, extension did the work
            s2_func <= s1_func;
            s2_dest <= s1_dest;
            s2_rob  <= s1_rob;
        end
        if (vld[1]) begin                                       // stage 3
            mul_result <= (s2_func == MUL_LO) ? s2_prod[XLEN-1:0]
                                              : s2_prod[2*XLEN-1:XLEN];
            mul_dest   <= s2_dest;
            mul_rob    <= s2_rob;
        end
    end

    assign mul_done = vld[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/psel_gen.sv ====
/*
 * lowest-index priority selector
 * one-hot grant of the lowest requesting bit, empty when nobody asks
 */
`default_nettype none

module psel_gen #(
    parameter int WIDTH = 4
) (
    input  wire logic [WIDTH-1:0] req,    // request per slot
    output logic      [WIDTH-1:0] gnt,    // one-hot, lowest req wins
    output logic                  empty   // no request at all
);

    ////////////////////////////////////////
    // lowest set bit isolation
    ////////////////////////////////////////
    // two's complement of req flips every bit above the lowest one,
    // and the and keeps only that lowest bit
    logic [WIDTH-1:0] req_neg;

    assign req_neg = ~req + 1'b1;       // -req
    assign gnt     = req & req_neg;     // lowest requester only
    assign empty   = ~|req;             // all zero

endmodule

`default_nettype wire

// ==== hdl/rs_mul.sv ====
/*
 * multiply reservation station
 * four entries, dispatch into the lowest free slot, cdb wakeup of
 * waiting operands, lowest-index issue of ready entries
 * only one multiply in flight: reissue waits for its cdb broadcast
 */
`default_nettype none

module rs_mul import mul_pkg::*; (
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      commit_mis_pred,   // squash everything
    // dispatch
    input  wire logic      dispatch_en,
    input  wire logic      opa_ready,
    input  wire xlen_t     opa_value,
    input  wire logic      opb_ready,
    input  wire xlen_t     opb_value,
    input  wire preg_idx_t opa_preg,
    input  wire preg_idx_t opb_preg,
    input  wire preg_idx_t dest_preg,
    input  wire rob_idx_t  rob_idx,
    input  wire mul_func_t func,
    // cdb
    input  wire logic      cdb_valid,
    input  wire preg_idx_t cdb_dest,
    input  wire xlen_t     cdb_value,
    input  wire logic      cdb_is_mul,
    // issue to the multiplier
    output logic           issue_valid,
    output xlen_t          issue_opa,
    output xlen_t          issue_opb,
    output mul_func_t      issue_func,
    output preg_idx_t      issue_dest,
    output rob_idx_t       issue_rob,
    output logic           rs_full
);

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////
    rs_mul_vec_t entry_free;               // 1 = slot empty
    rs_mul_vec_t opa_rdy;                  // operand a holds a value
    rs_mul_vec_t opb_rdy;
    xlen_t       opa_fld [RS_MUL_SIZE];    // value, or tag while waiting
    xlen_t       opb_fld [RS_MUL_SIZE];
    mul_func_t   func_q  [RS_MUL_SIZE];
    preg_idx_t   dest_q  [RS_MUL_SIZE];
    rob_idx_t    rob_q   [RS_MUL_SIZE];

    logic [RS_MUL_LEN:0] occ_cnt;          // 0..RS_MUL_SIZE
    logic        issued_before;            // a multiply left since reset/squash

    rs_mul_vec_t free_gnt;                 // lowest free slot
    logic        free_empty;
    rs_mul_vec_t disp_gnt;                 // slot written this cycle
    logic        disp_ok;
    rs_mul_vec_t ready_vec;                // both operands present
    rs_mul_vec_t sel_gnt;
    logic        sel_empty;
    rs_mul_idx_t sel_idx;
    logic        issue_ok;
    logic        disp_hit_a;               // dispatch tag seen on cdb right now
    logic        disp_hit_b;
    rs_mul_vec_t wake_a;
    rs_mul_vec_t wake_b;

    ////////////////////////////////////////
    // selection
    ////////////////////////////////////////
    psel_gen #(.WIDTH(RS_MUL_SIZE)) u_free_sel (
        .req   (entry_free),
        .gnt   (free_gnt),
        .empty (free_empty)
    );

    assign ready_vec = ~entry_free & opa_rdy & opb_rdy;

    psel_gen #(.WIDTH(RS_MUL_SIZE)) u_issue_sel (
        .req   (ready_vec),
        .gnt   (sel_gnt),
        .empty (sel_empty)
    );

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < RS_MUL_SIZE; i++) begin
            if (sel_gnt[i]) sel_idx = rs_mul_idx_t'(i);   // one-hot to binary
        end
    end

    assign disp_ok  = dispatch_en & ~free_empty;          // dispatcher honours rs_full
    assign disp_gnt = free_gnt & {RS_MUL_SIZE{disp_ok}};
    // first issue is free, later ones ride on the previous result's broadcast
    assign issue_ok = ~sel_empty & (~issued_before | (cdb_valid & cdb_is_mul));
    assign rs_full  = (occ_cnt == (RS_MUL_LEN+1)'(RS_MUL_SIZE));

    ////////////////////////////////////////
    // cdb tag match
    ////////////////////////////////////////
    assign disp_hit_a = cdb_valid & ~opa_ready & (cdb_dest == opa_preg);
    assign disp_hit_b = cdb_valid & ~opb_ready & (cdb_dest == opb_preg);

    always_comb begin
        for (int i = 0; i < RS_MUL_SIZE; i++) begin
            // waiting operands keep their tag in the low bits
            wake_a[i] = cdb_valid & ~entry_free[i] & ~opa_rdy[i]
                      & (opa_fld[i][PRF_LEN-1:0] == cdb_dest);
            wake_b[i] = cdb_valid & ~entry_free[i] & ~opb_rdy[i]
                      & (opb_fld[i][PRF_LEN-1:0] == cdb_dest);
        end
    end

    ////////////////////////////////////////
    // control state
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || commit_mis_pred) begin
            entry_free    <= '1;
            occ_cnt       <= '0;
            issued_before <= 1'b0;
            issue_valid   <= 1'b0;
        end else begin
            occ_cnt     <= occ_cnt + {{RS_MUL_LEN{1'b0}}, disp_ok}
                                   - {{RS_MUL_LEN{1'b0}}, issue_ok};
            issue_valid <= issue_ok;
            if (issue_ok) issued_before <= 1'b1;
            for (int i = 0; i < RS_MUL_SIZE; i++) begin
                if (disp_gnt[i]) entry_free[i] <= 1'b0;              // only free slots
                else if (issue_ok && sel_gnt[i]) entry_free[i] <= 1'b1; // only busy slots
            end
        end
    end

    ////////////////////////////////////////
    // entry payload and issue register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (issue_ok) begin
            issue_opa  <= opa_fld[sel_idx];
            issue_opb  <= opb_fld[sel_idx];
            issue_func <= func_q[sel_idx];
            issue_dest <= dest_q[sel_idx];
            issue_rob  <= rob_q[sel_idx];
        end
        for (int i = 0; i < RS_MUL_SIZE; i++) begin
            if (disp_gnt[i]) begin
                // same-cycle broadcast is taken straight from the bus
                opa_rdy[i] <= opa_ready | disp_hit_a;
                opb_rdy[i] <= opb_ready | disp_hit_b;
                opa_fld[i] <= opa_ready  ? opa_value :
                              disp_hit_a ? cdb_value : xlen_t'(opa_preg);
                opb_fld[i] <= opb_ready  ? opb_value :
                              disp_hit_b ? cdb_value : xlen_t'(opb_preg);
                func_q[i]  <= func;
                dest_q[i]  <= dest_preg;
                rob_q[i]   <= rob_idx;
            end else begin
                if (wake_a[i]) begin
                    opa_rdy[i] <= 1'b1;
                    opa_fld[i] <= cdb_value;   // tag replaced by value
                end
                if (wake_b[i]) begin
                    opb_rdy[i] <= 1'b1;
                    opb_fld[i] <= cdb_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the multiply issue path testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_mul_issue -f files.f -o tb_mul_issue
./obj_dir/tb_mul_issue | tee sim.log

# any mismatch or timeout ends in the fail line
if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
